// ==== rtl/icache_pkg.sv ====
/* widths assume a 32-bit physical byte address and 16-byte lines
   set and way counts are module parameters of icache_top */
package icache_pkg;

  ////////////////////////////////
  // address and data widths
  ////////////////////////////////

  // physical byte address
  parameter int unsigned ADDR_W     = 32;
  // one fetch word
  parameter int unsigned WORD_W     = 32;
  // words per cache line
  parameter int unsigned LINE_WORDS = 4;
  // full line moved in one memory transfer
  parameter int unsigned LINE_W     = LINE_WORDS * WORD_W;
  // byte offset bits inside a line
  parameter int unsigned OFFSET_W   = 4;

  ////////////////////////////////
  // types
  ////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  // word k sits at bits 32k upward
  typedef logic [LINE_W-1:0] line_t;

  // controller states
  // FLUSH walks all sets clearing valid bits
  // READ is the tag compare cycle and MISS waits for the refill line
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

// ==== rtl/icache_ctrl.sv ====
/* flush walk takes NumSets cycles with ready low
   a flush seen during a fetch waits for that fetch to finish */
module icache_ctrl import icache_pkg::*; #(
  parameter int unsigned NumSets = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       en_i,
  input  logic                       flush_i,
  input  logic                       req_i,
  input  logic                       hit_i,
  input  logic                       mem_ack_i,
  input  logic                       mem_rtrn_vld_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output logic                       miss_o,
  output logic                       mem_req_o,
  output logic                       mem_nc_o,
  output logic                       rd_en_o,
  output logic                       fill_we_o,
  output logic                       clr_en_o,
  output logic                       cmp_en_o,
  output logic [$clog2(NumSets)-1:0] clr_idx_o
);

  localparam int unsigned IdxW = $clog2(NumSets);

  ctrl_state_e state_d, state_q;
  // cache enable that may only rise through a flush walk
  logic cache_en_d, cache_en_q;
  // remembered flush request
  logic flush_d, flush_q;
  // tag compare valid in the next cycle
  logic cmp_en_d, cmp_en_q;
  logic [IdxW-1:0] flush_cnt_d, flush_cnt_q;
  logic flush_done;
  logic hit;

  assign flush_done = (flush_cnt_q == IdxW'(NumSets - 1));
  // a hit only counts after a real compare with the cache on
  assign hit        = hit_i & cmp_en_q & cache_en_q;

  ////////////////////////////////
  // fsm
  ////////////////////////////////

  always_comb begin
    state_d   = state_q;
    flush_d   = flush_q | flush_i;
    ready_o   = 1'b0;
    valid_o   = 1'b0;
    miss_o    = 1'b0;
    mem_req_o = 1'b0;
    rd_en_o   = 1'b0;
    fill_we_o = 1'b0;
    clr_en_o  = 1'b0;

    unique case (state_q)
      FLUSH: begin
        // one set cleared per cycle
        clr_en_o = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
        end
      end
      IDLE: begin
        // pending flush or enable rise goes through the walk first
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      READ: begin
        if (hit) begin
          valid_o = 1'b1;
          state_d = IDLE;
          // next fetch reads while this one returns
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              rd_en_o = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // miss or non-cacheable fetch holds the request until ack
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o   = 1'b1;
          // disabled cache never writes the arrays
          fill_we_o = cache_en_q;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase

    // enable is sampled at the end of a walk
    // otherwise it may only drop, and stays put while memory is busy
    if (state_q == FLUSH && flush_done) begin
      cache_en_d = en_i;
    end else if (mem_req_o || state_q == MISS) begin
      cache_en_d = cache_en_q;
    end else begin
      cache_en_d = cache_en_q & en_i;
    end
  end

  assign cmp_en_d = rd_en_o & cache_en_q;

  assign flush_cnt_d = !clr_en_o  ? flush_cnt_q :
                       flush_done ? '0          :
                                    flush_cnt_q + 1'b1;

  ////////////////////////////////
  // state registers
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      cmp_en_q    <= cmp_en_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  assign cmp_en_o  = cmp_en_q;
  assign mem_nc_o  = ~cache_en_q;
  assign clr_idx_o = flush_cnt_q;

endmodule

// ==== rtl/icache_way_mem.sv ====
/* one read or one write per cycle at idx_i; clear and write never coincide
   read data holds until the next read enable */
module icache_way_mem import icache_pkg::*; #(
  parameter int unsigned NumSets = 16
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        rd_en_i,
  input  logic                                        we_i,
  input  logic                                        clr_i,
  input  logic [$clog2(NumSets)-1:0]                  idx_i,
  input  logic [$clog2(NumSets)-1:0]                  clr_idx_i,
  input  logic [ADDR_W-$clog2(NumSets)-OFFSET_W-1:0]  tag_i,
  input  line_t                                       line_i,
  output logic [ADDR_W-$clog2(NumSets)-OFFSET_W-1:0]  tag_o,
  output logic                                        vld_o,
  output line_t                                       line_o
);

  localparam int unsigned IdxW = $clog2(NumSets);
  localparam int unsigned TagW = ADDR_W - IdxW - OFFSET_W;

  logic [TagW-1:0] tag_mem [NumSets];
  line_t           line_mem [NumSets];
  // one valid bit per set
  logic [NumSets-1:0] vld_q;

  // tag and line arrays, synchronous read
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      tag_mem[idx_i]  <= tag_i;
      line_mem[idx_i] <= line_i;
    end
    if (rd_en_i) begin
      tag_o  <= tag_mem[idx_i];
      line_o <= line_mem[idx_i];
    end
  end

  // valid bits are set by fill and cleared by the flush walk
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
      vld_o <= 1'b0;
    end else begin
      if (clr_i) begin
        vld_q[clr_idx_i] <= 1'b0;
      end else if (we_i) begin
        vld_q[idx_i] <= 1'b1;
      end
      if (rd_en_i) begin
        vld_o <= vld_q[idx_i];
      end
    end
  end

endmodule

// ==== rtl/icache_victim_sel.sv ====
/* NumWays is a power of two between 2 and 256
   victim is captured in the compare cycle and held through the miss */
module icache_victim_sel import icache_pkg::*; #(
  parameter int unsigned NumWays = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmp_en_i,
  input  logic               fill_we_i,
  input  logic [NumWays-1:0] vld_i,
  output logic [NumWays-1:0] victim_oh_o
);

  localparam int unsigned WayW = $clog2(NumWays);

  logic [WayW-1:0]    inv_way;
  logic [WayW-1:0]    repl_way;
  logic               all_valid;
  logic               full_q;
  logic [7:0]         lfsr_q;
  logic               lfsr_fb;
  logic [NumWays-1:0] victim_oh_q;

  ////////////////////////////////
  // first invalid way
  ////////////////////////////////

  // scan downward so the lowest free way wins
  always_comb begin
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!vld_i[w]) begin
        inv_way = WayW'(w);
      end
    end
  end

  assign all_valid = &vld_i;
  // random pick only once the set is full
  assign repl_way  = all_valid ? lfsr_q[WayW-1:0] : inv_way;

  ////////////////////////////////
  // lfsr and victim register
  ////////////////////////////////

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= 8'hff;
      full_q      <= 1'b0;
      victim_oh_q <= '0;
    end else begin
      if (cmp_en_i) begin
        victim_oh_q           <= '0;
        victim_oh_q[repl_way] <= 1'b1;
        full_q                <= all_valid;
      end
      // step only when a random victim was consumed
      if (fill_we_i && full_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

  assign victim_oh_o = victim_oh_q;

endmodule

// ==== rtl/icache_hit_sel.sv ====
/* purely combinational, valid for the cycle after an array read
   several hitting ways resolve to the lowest one */
module icache_hit_sel import icache_pkg::*; #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16
) (
  input  logic                                                     cmp_en_i,
  input  logic [ADDR_W-$clog2(NumSets)-OFFSET_W-1:0]               tag_i,
  input  logic [NumWays-1:0][ADDR_W-$clog2(NumSets)-OFFSET_W-1:0]  way_tags_i,
  input  logic [NumWays-1:0]                                       way_vld_i,
  input  line_t [NumWays-1:0]                                      way_lines_i,
  input  line_t                                                    rtrn_line_i,
  input  logic [$clog2(LINE_WORDS)-1:0]                            offset_i,
  output logic                                                     hit_o,
  output word_t                                                    data_o
);

  localparam int unsigned WayW = $clog2(NumWays);

  logic [NumWays-1:0] way_hit;
  logic [WayW-1:0]    hit_way;

  // tag compare per valid way
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign way_hit[w] = way_vld_i[w] & (way_tags_i[w] == tag_i);
  end

  assign hit_o = |way_hit;

  // lowest hitting way
  always_comb begin
    hit_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = WayW'(w);
      end
    end
  end

  // word from the array on a compare, else from the returning line
  always_comb begin
    if (cmp_en_i) begin
      data_o = way_lines_i[hit_way][offset_i*WORD_W +: WORD_W];
    end else begin
      data_o = rtrn_line_i[offset_i*WORD_W +: WORD_W];
    end
  end

endmodule

// ==== rtl/icache_top.sv ====
/* fetch addresses are physical, low two bits ignored; NumWays >= 2
   refill line must arrive only after mem_ack_i and is taken unconditionally */
module icache_top import icache_pkg::*; #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  en_i,
  input  logic  flush_i,
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  ready_o,
  output logic  valid_o,
  output word_t data_o,
  output logic  miss_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_nc_o,
  input  logic  mem_ack_i,
  input  logic  mem_rtrn_vld_i,
  input  line_t mem_rtrn_data_i
);

  localparam int unsigned IdxW  = $clog2(NumSets);
  localparam int unsigned TagW  = ADDR_W - IdxW - OFFSET_W;
  localparam int unsigned WOffW = $clog2(LINE_WORDS);

  addr_t addr_d, addr_q;
  logic [IdxW-1:0] idx;
  logic [TagW-1:0] tag;
  logic [WOffW-1:0] word_off;

  logic rd_en, fill_we, clr_en, cmp_en, hit;
  logic [IdxW-1:0] clr_idx;

  logic [NumWays-1:0][TagW-1:0] way_tags;
  logic [NumWays-1:0]           way_vld;
  line_t [NumWays-1:0]          way_lines;
  logic [NumWays-1:0]           victim_oh;

  ////////////////////////////////
  // address capture and split
  ////////////////////////////////

  // array read at acceptance uses the incoming address directly
  assign addr_d = (req_i && ready_o) ? addr_i : addr_q;

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

  assign idx        = addr_d[OFFSET_W +: IdxW];
  // compare and fill use the registered address
  assign tag        = addr_q[ADDR_W-1 -: TagW];
  assign word_off   = addr_q[2 +: WOffW];
  // refill always fetches a whole aligned line
  assign mem_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  ////////////////////////////////
  // submodules
  ////////////////////////////////

  icache_ctrl #(
    .NumSets(NumSets)
  ) u_ctrl (
    .clk_i,
    .rst_ni,
    .en_i,
    .flush_i,
    .req_i,
    .hit_i          (hit),
    .mem_ack_i,
    .mem_rtrn_vld_i,
    .ready_o,
    .valid_o,
    .miss_o,
    .mem_req_o,
    .mem_nc_o,
    .rd_en_o        (rd_en),
    .fill_we_o      (fill_we),
    .clr_en_o       (clr_en),
    .cmp_en_o       (cmp_en),
    .clr_idx_o      (clr_idx)
  );

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    // only the victim way takes the refill
    icache_way_mem #(
      .NumSets(NumSets)
    ) u_way (
      .clk_i,
      .rst_ni,
      .rd_en_i   (rd_en),
      .we_i      (fill_we & victim_oh[w]),
      .clr_i     (clr_en),
      .idx_i     (idx),
      .clr_idx_i (clr_idx),
      .tag_i     (tag),
      .line_i    (mem_rtrn_data_i),
      .tag_o     (way_tags[w]),
      .vld_o     (way_vld[w]),
      .line_o    (way_lines[w])
    );
  end

  icache_victim_sel #(
    .NumWays(NumWays)
  ) u_victim (
    .clk_i,
    .rst_ni,
    .cmp_en_i    (cmp_en),
    .fill_we_i   (fill_we),
    .vld_i       (way_vld),
    .victim_oh_o (victim_oh)
  );

  icache_hit_sel #(
    .NumWays(NumWays),
    .NumSets(NumSets)
  ) u_hit (
    .cmp_en_i    (cmp_en),
    .tag_i       (tag),
    .way_tags_i  (way_tags),
    .way_vld_i   (way_vld),
    .way_lines_i (way_lines),
    .rtrn_line_i (mem_rtrn_data_i),
    .offset_i    (word_off),
    .hit_o       (hit),
    .data_o
  );

endmodule

// ==== dv/icache_chk.sv ====
/* bound into icache_top; assumes one outstanding refill at a time */
module icache_chk import icache_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  ready_o,
  input logic  miss_o,
  input logic  mem_req_o,
  input addr_t mem_addr_o,
  input logic  mem_nc_o,
  input logic  mem_ack_i
);

  //////////////////////////////
  // memory handshake
  //////////////////////////////

  // request, line address and nc bit hold until the acknowledge
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_nc_o))
    else $error("mem_req_o dropped or changed before mem_ack_i");

  // no new fetch accepted while a refill request is open
  req_blocks_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> !ready_o)
    else $error("ready_o high while mem_req_o is pending");

  // miss pulse only in the acknowledge cycle
  miss_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_o |-> mem_ack_i && mem_req_o)
    else $error("miss_o high without an acknowledged request");

endmodule

bind icache_top icache_chk u_chk (.*);

// ==== dv/icache_tb.sv ====
/* line_addr assumes the 16-byte line layout of icache_pkg
   memory model serves one refill at a time with a 0-1 cycle ack and a 1-3 cycle return */
module icache_tb import icache_pkg::*;;

  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumSets     = 16;
  localparam int unsigned IdxW        = $clog2(NumSets);
  localparam int unsigned ResetCycles = 16;
  // worst fetch is accept, compare, ack wait, return wait and slack
  localparam int unsigned MissMax     = 10;
  localparam int unsigned NumFetches  = 56;
  // reset, flush and re-enable walks
  localparam int unsigned NumWalks    = 3;
  localparam int unsigned MaxCycles   = ResetCycles + NumWalks * (NumSets + 2)
                                        + NumFetches * MissMax;

  logic  clk_i, rst_ni, en_i, flush_i, req_i;
  addr_t addr_i;
  logic  ready_o, valid_o, miss_o, mem_req_o, mem_nc_o;
  word_t data_o;
  addr_t mem_addr_o;
  logic  mem_ack_i, mem_rtrn_vld_i;
  line_t mem_rtrn_data_i;

  string       test_name;
  addr_t       exp_q[$];
  int unsigned cycle_cnt  = 0;
  int unsigned word_errs  = 0;
  int unsigned flag_errs  = 0;
  int unsigned addr_errs  = 0;
  int unsigned other_errs = 0;

  icache_top #(
    .NumWays(NumWays),
    .NumSets(NumSets)
  ) DUT (
    .clk_i, .rst_ni, .en_i, .flush_i, .req_i, .addr_i,
    .ready_o, .valid_o, .data_o, .miss_o,
    .mem_req_o, .mem_addr_o, .mem_nc_o,
    .mem_ack_i, .mem_rtrn_vld_i, .mem_rtrn_data_i
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // memory word is a fixed scramble of its word address
  function automatic word_t exp_word(input addr_t a);
    logic [29:0] w;
    w = a[ADDR_W-1:2];
    return ({2'b00, w} * 32'h9e37_79b1) ^ {w[13:0], w[29:12]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic line_t make_line(input addr_t a);
    line_t l;
    for (int k = 0; k < LINE_WORDS; k++) begin
      l[k*WORD_W +: WORD_W] = exp_word({a[ADDR_W-1:OFFSET_W], k[1:0], 2'b00});
    end
    return l;
  endfunction

  // byte address of a line from its tag and set
  function automatic addr_t line_addr(input int unsigned tag, input int unsigned set);
    return (addr_t'(tag) << (OFFSET_W + IdxW)) | (addr_t'(set) << OFFSET_W);
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      flag_errs++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      addr_errs++;
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  initial begin : mem_model
    addr_t       req_addr;
    int unsigned ack_dly;
    int unsigned rtrn_dly;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    void'($urandom(39));
    forever begin
      @(posedge clk_i);
      if (mem_req_o) begin
        req_addr = mem_addr_o;
        ack_dly  = $urandom % 2;
        rtrn_dly = $urandom % 3;
        repeat (ack_dly) @(posedge clk_i);
        #1 mem_ack_i = 1'b1;
        @(posedge clk_i);
        #1 mem_ack_i = 1'b0;
        // line returns 1 to 3 cycles after the ack cycle
        repeat (rtrn_dly) begin
          @(posedge clk_i);
          #1;
        end
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_data_i = make_line(req_addr);
        @(posedge clk_i);
        #1 mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  // every valid_o word is matched against the oldest accepted fetch
  always @(posedge clk_i) begin : compare
    addr_t a;
    if (valid_o) begin
      if (exp_q.size() == 0) begin
        $display("valid_o at cycle %0d with no fetch outstanding", cycle_cnt);
        other_errs++;
      end else begin
        a = exp_q.pop_front();
        check_word(test_name, exp_word(a), data_o);
      end
    end
    if (rst_ni && req_i && ready_o) begin
      exp_q.push_back(addr_i);
    end
  end

  always @(posedge clk_i) begin : timeout
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: run did not end within %0d cycles", MaxCycles);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // one fetch that starts and ends just after a rising edge
  task automatic fetch(input addr_t a, output logic req_seen, output logic nc_seen,
                       output logic miss_seen);
    int unsigned waited;
    logic        accepted;
    logic        got_valid;
    addr_t       line_a;
    req_seen  = 1'b0;
    nc_seen   = 1'b0;
    miss_seen = 1'b0;
    accepted  = 1'b0;
    got_valid = 1'b0;
    waited    = 0;
    // refill asks for the whole line holding the fetch address
    line_a    = a & ~addr_t'((1 << OFFSET_W) - 1);
    req_i     = 1'b1;
    addr_i    = a;
    // ready may stay low for a whole flush walk
    while (!accepted && waited < NumSets + 4) begin
      @(posedge clk_i);
      accepted = ready_o;
      waited++;
    end
    #1 req_i = 1'b0;
    if (!accepted) begin
      $display("fetch to %h was never accepted", a);
      other_errs++;
      return;
    end
    waited = 0;
    while (!got_valid && waited < MissMax) begin
      @(posedge clk_i);
      if (mem_req_o) begin
        req_seen = 1'b1;
        nc_seen  = mem_nc_o;
        check_addr({test_name, " mem_addr"}, line_a, mem_addr_o);
      end
      if (miss_o) begin
        miss_seen = 1'b1;
      end
      got_valid = valid_o;
      waited++;
    end
    #1;
    if (!got_valid) begin
      $display("fetch to %h got no valid_o within %0d cycles", a, MissMax);
      other_errs++;
    end
  endtask

  task automatic fetch_expect(input addr_t a, input logic exp_req, input logic exp_nc,
                              input logic exp_miss);
    logic req_seen, nc_seen, miss_seen;
    fetch(a, req_seen, nc_seen, miss_seen);
    check_flag({test_name, " mem_req"}, exp_req, req_seen);
    check_flag({test_name, " mem_nc"}, exp_nc, nc_seen);
    check_flag({test_name, " miss"}, exp_miss, miss_seen);
  endtask

  // holds req_i high; each accept must give valid_o on the next edge
  task automatic burst_hits(input int unsigned n);
    int unsigned sent;
    logic        prev_acc;
    sent     = 0;
    prev_acc = 1'b0;
    req_i    = 1'b1;
    addr_i   = line_addr(1, 5);
    while (sent < n || prev_acc) begin
      @(posedge clk_i);
      if (prev_acc) begin
        check_flag({test_name, " valid"}, 1'b1, valid_o);
      end
      if (sent > 0 && sent < n) begin
        check_flag({test_name, " ready"}, 1'b1, ready_o);
      end
      prev_acc = req_i && ready_o;
      if (prev_acc) begin
        sent++;
      end
      #1;
      if (sent < n) begin
        addr_i = line_addr(sent % NumWays + 1, 5) + addr_t'(4 * ((sent / NumWays) % 4));
      end else begin
        req_i = 1'b0;
      end
    end
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : stimulus
    logic req_seen, nc_seen, miss_seen;
    logic any_req;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    en_i      = 1'b1;
    flush_i   = 1'b0;
    req_i     = 1'b0;
    addr_i    = '0;
    test_name = "reset";
    repeat (ResetCycles) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // four lines share set 5 and one more sits alone in set 2
    test_name = "cold";
    for (int unsigned i = 1; i <= NumWays; i++) begin
      fetch_expect(line_addr(i, 5) + addr_t'(4 * (i % 4)), 1'b1, 1'b0, 1'b1);
    end
    fetch_expect(line_addr(7, 2) + 8, 1'b1, 1'b0, 1'b1);

    // invalid ways fill first so all four lines stay resident
    test_name = "hits";
    for (int unsigned i = 1; i <= NumWays; i++) begin
      for (int unsigned k = 0; k < LINE_WORDS; k++) begin
        fetch_expect(line_addr(i, 5) + addr_t'(4 * k), 1'b0, 1'b0, 1'b0);
      end
    end

    test_name = "b2b";
    burst_hits(16);

    // fifth line forces an lfsr victim
    test_name = "replace";
    fetch_expect(line_addr(5, 5) + 4, 1'b1, 1'b0, 1'b1);
    for (int unsigned r = 0; r < 2; r++) begin
      any_req = 1'b0;
      for (int unsigned i = 1; i <= 5; i++) begin
        fetch(line_addr(i, 5) + addr_t'(4 * r), req_seen, nc_seen, miss_seen);
        check_flag({test_name, " mem_nc"}, 1'b0, nc_seen);
        any_req = any_req | req_seen;
      end
      // five lines cannot all fit four ways
      check_flag({test_name, " refill per round"}, 1'b1, any_req);
    end

    test_name = "flush";
    fetch_expect(line_addr(7, 2), 1'b0, 1'b0, 1'b0);
    pulse_flush();
    fetch_expect(line_addr(7, 2) + 4, 1'b1, 1'b0, 1'b1);

    // resident line is bypassed while disabled
    test_name = "disabled";
    en_i = 1'b0;
    @(posedge clk_i);
    #1;
    fetch_expect(line_addr(7, 2), 1'b1, 1'b1, 1'b0);
    fetch_expect(line_addr(7, 2), 1'b1, 1'b1, 1'b0);
    fetch_expect(line_addr(1, 5) + 12, 1'b1, 1'b1, 1'b0);

    // enable rise walks the sets again
    test_name = "reenable";
    en_i = 1'b1;
    fetch_expect(line_addr(7, 2) + 12, 1'b1, 1'b0, 1'b1);

    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d accepted fetches never returned valid_o", exp_q.size());
      other_errs++;
    end
    $display("errors: %0d data, %0d flag, %0d addr, %0d other",
             word_errs, flag_errs, addr_errs, other_errs);
    if (word_errs + flag_errs + addr_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
rtl/icache_pkg.sv
rtl/icache_ctrl.sv
rtl/icache_way_mem.sv
rtl/icache_victim_sel.sv
rtl/icache_hit_sel.sv
rtl/icache_top.sv
dv/icache_chk.sv
dv/icache_tb.sv

// ==== Makefile ====
TOP := icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir
